// ==== flist.f ====
logic/vga_pkg.sv
logic/video_timing_if.sv
logic/hvsync_generator.sv
logic/color_bars.sv
logic/ball_sprite.sv
logic/pixel_mixer.sv
logic/vga_top.sv
verif/tb_vga_top.sv

// ==== logic/ball_sprite.sv ====
`timescale 1ns/1ns

// square ball, moves once per frame, bounces off the screen edges
module ball_sprite (
  input  logic           clk,
  input  logic           reset,
  video_timing_if.sink   vt,
  output logic           ball_hit
);

  logic [vga_pkg::POS_W-1:0] ball_x;   // left column
  logic [vga_pkg::POS_W-1:0] ball_y;   // top line
  logic                      dir_x;    // 1 = moving right
  logic                      dir_y;    // 1 = moving down
  logic                      frame_tick;
  logic [vga_pkg::POS_W:0]   next_x;   // {dir, pos}
  logic [vga_pkg::POS_W:0]   next_y;
  logic                      in_x;
  logic                      in_y;

  // one axis of the bounce rule, returns {new dir, new pos}
  function automatic logic [vga_pkg::POS_W:0] axis_step(
    input logic [vga_pkg::POS_W-1:0] pos,
    input logic                      dir,
    input logic [vga_pkg::POS_W-1:0] limit
  );
    logic                      ndir;
    logic [vga_pkg::POS_W-1:0] npos;
    ndir = dir;
    if (dir && (pos + vga_pkg::BALL_STEP > limit))
      ndir = 1'b0;                   // would pass far edge
    else if (!dir && (pos < vga_pkg::BALL_STEP))
      ndir = 1'b1;                   // would go below zero
    // step is always taken, in the new direction
    if (ndir)
      npos = pos + vga_pkg::BALL_STEP;
    else
      npos = pos - vga_pkg::BALL_STEP;
    return {ndir, npos};
  endfunction

  // first blanked line, so the visible frame sees one position
  assign frame_tick = (vt.hpos == '0) && (vt.vpos == vga_pkg::V_DISPLAY);

  assign next_x = axis_step(ball_x, dir_x, vga_pkg::H_DISPLAY - vga_pkg::BALL_SIZE);
  assign next_y = axis_step(ball_y, dir_y, vga_pkg::V_DISPLAY - vga_pkg::BALL_SIZE);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ball_x <= vga_pkg::BALL_X0;
      ball_y <= vga_pkg::BALL_Y0;
      dir_x  <= 1'b1;                // start heading right
      dir_y  <= 1'b1;                // and down
    end
    else if (frame_tick)
    begin
      dir_x  <= next_x[vga_pkg::POS_W];
      ball_x <= next_x[vga_pkg::POS_W-1:0];
      dir_y  <= next_y[vga_pkg::POS_W];
      ball_y <= next_y[vga_pkg::POS_W-1:0];
    end
  end

  // no overflow here, x stays <= 624 and y <= 464
  assign in_x = (vt.hpos >= ball_x) && (vt.hpos < ball_x + vga_pkg::BALL_SIZE);
  assign in_y = (vt.vpos >= ball_y) && (vt.vpos < ball_y + vga_pkg::BALL_SIZE);

  assign ball_hit = in_x && in_y;

endmodule

// ==== logic/color_bars.sv ====
`timescale 1ns/1ns

// eight vertical bars plus optional grid flag
module color_bars (
  video_timing_if.sink                  vt,
  input  logic                          grid_on,  // level, not synchronized
  output logic [vga_pkg::RGB_W-1:0]     bar_rgb,
  output logic                          grid_hit
);

  logic [vga_pkg::POS_W-1:0] bar_idx; // 0..7 while visible
  logic                      h_line;  // column on grid
  logic                      v_line;  // row on grid

  // constant divide, 80 pixels per bar
  assign bar_idx = vt.hpos / vga_pkg::BAR_WIDTH;

  // index doubles as the color: 0 black ... 7 white
  // past 639 the index runs to 9 but the mixer blanks there
  assign bar_rgb = bar_idx[vga_pkg::RGB_W-1:0];

  // grid lines every 32 pixels on both axes
  assign h_line = (vt.hpos[vga_pkg::GRID_SHIFT-1:0] == '0);
  assign v_line = (vt.vpos[vga_pkg::GRID_SHIFT-1:0] == '0);

  assign grid_hit = grid_on && (h_line || v_line);

endmodule

// ==== logic/hvsync_generator.sv ====
`timescale 1ns/1ns

// 640x480 raster timing, active high syncs
module hvsync_generator (
  input  logic                  clk,
  input  logic                  reset,
  video_timing_if.source        vt
);

  logic hmaxxed; // last pixel of the line
  logic vmaxxed; // last line of the frame

  assign hmaxxed = (vt.hpos == vga_pkg::H_MAX);
  assign vmaxxed = (vt.vpos == vga_pkg::V_MAX);

  // horizontal counter, free running
  always_ff @(posedge clk)
  begin
    if (reset)
      vt.hpos <= '0;
    else if (hmaxxed)
      vt.hpos <= '0;                 // wrap after 799
    else
      vt.hpos <= vt.hpos + 1'b1;
  end

  // vertical counter steps once per line
  always_ff @(posedge clk)
  begin
    if (reset)
      vt.vpos <= '0;
    else if (hmaxxed)
    begin
      if (vmaxxed)
        vt.vpos <= '0;               // wrap after 524
      else
        vt.vpos <= vt.vpos + 1'b1;
    end
  end

  // sync windows are inclusive at both ends
  assign vt.hsync = (vt.hpos >= vga_pkg::H_SYNC_START) &&
                    (vt.hpos <= vga_pkg::H_SYNC_END);
  assign vt.vsync = (vt.vpos >= vga_pkg::V_SYNC_START) &&
                    (vt.vpos <= vga_pkg::V_SYNC_END);

  // visible area, top left is 0,0
  assign vt.display_on = (vt.hpos < vga_pkg::H_DISPLAY) &&
                         (vt.vpos < vga_pkg::V_DISPLAY);

endmodule

// ==== logic/pixel_mixer.sv ====
`timescale 1ns/1ns

// layer priority ball > grid > bar, blanking, output register
module pixel_mixer (
  input  logic                          clk,
  input  logic                          reset,
  video_timing_if.sink                  vt,
  input  logic [vga_pkg::RGB_W-1:0]     bar_rgb,
  input  logic                          grid_hit,
  input  logic                          ball_hit,
  output logic                          hsync,
  output logic                          vsync,
  output logic                          de,
  output logic [vga_pkg::RGB_W-1:0]     rgb
);

  logic [vga_pkg::RGB_W-1:0] pix_rgb; // color before the register

  always_comb
  begin
    if (!vt.display_on)
      pix_rgb = vga_pkg::COLOR_BLANK;   // porches and sync
    else if (ball_hit)
      pix_rgb = vga_pkg::COLOR_BALL;
    else if (grid_hit)
      pix_rgb = vga_pkg::COLOR_GRID;
    else
      pix_rgb = bar_rgb;
  end

  // syncs ride through the same stage so they stay aligned with rgb
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      de    <= 1'b0;
      rgb   <= vga_pkg::COLOR_BLANK;
    end
    else
    begin
      hsync <= vt.hsync;
      vsync <= vt.vsync;
      de    <= vt.display_on;   // visible flag leaves as de
      rgb   <= pix_rgb;
    end
  end

endmodule

// ==== logic/vga_pkg.sv ====
package vga_pkg;

  // raster counters are 10 bits, enough for 800 x 525
  localparam int POS_W = 10;

  // horizontal timing, in pixels
  localparam logic [POS_W-1:0] H_DISPLAY = 10'd640; // visible width
  localparam logic [POS_W-1:0] H_FRONT   = 10'd16;  // right border
  localparam logic [POS_W-1:0] H_SYNC    = 10'd96;  // sync pulse
  localparam logic [POS_W-1:0] H_BACK    = 10'd48;  // left border

  // vertical timing, in lines
  localparam logic [POS_W-1:0] V_DISPLAY = 10'd480; // visible height
  localparam logic [POS_W-1:0] V_BOTTOM  = 10'd10;  // bottom border
  localparam logic [POS_W-1:0] V_SYNC    = 10'd2;   // sync lines
  localparam logic [POS_W-1:0] V_TOP     = 10'd33;  // top border

  // derived window edges, inclusive
  localparam logic [POS_W-1:0] H_SYNC_START = H_DISPLAY + H_FRONT;              // 656
  localparam logic [POS_W-1:0] H_SYNC_END   = H_DISPLAY + H_FRONT + H_SYNC - 1; // 751
  localparam logic [POS_W-1:0] H_MAX = H_DISPLAY + H_FRONT + H_SYNC + H_BACK - 1; // 799
  localparam logic [POS_W-1:0] V_SYNC_START = V_DISPLAY + V_BOTTOM;              // 490
  localparam logic [POS_W-1:0] V_SYNC_END   = V_DISPLAY + V_BOTTOM + V_SYNC - 1; // 491
  localparam logic [POS_W-1:0] V_MAX = V_DISPLAY + V_BOTTOM + V_SYNC + V_TOP - 1; // 524

  // color bars and grid
  localparam logic [POS_W-1:0] BAR_WIDTH = 10'd80; // 8 bars over 640
  localparam int GRID_SHIFT = 5;                    // 32 pixel pitch

  // ball sprite
  localparam logic [POS_W-1:0] BALL_SIZE = 10'd16;  // square side
  localparam logic [POS_W-1:0] BALL_STEP = 10'd8;   // move per frame
  localparam logic [POS_W-1:0] BALL_X0   = 10'd600; // start, near right edge
  localparam logic [POS_W-1:0] BALL_Y0   = 10'd440; // start, near bottom

  // colors, one bit each of r g b
  localparam int RGB_W = 3;
  localparam logic [RGB_W-1:0] COLOR_GRID  = 3'd7; // white
  localparam logic [RGB_W-1:0] COLOR_BALL  = 3'd6; // yellow
  localparam logic [RGB_W-1:0] COLOR_BLANK = 3'd0; // black

endpackage

// ==== logic/vga_top.sv ====
`timescale 1ns/1ns

// vga subsystem: timing, bars, ball, mixer
module vga_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          grid_on,
  output logic                          hsync,
  output logic                          vsync,
  output logic                          de,
  output logic [vga_pkg::RGB_W-1:0]     rgb
);

  logic [vga_pkg::RGB_W-1:0] bar_rgb;  // background color
  logic                      grid_hit;
  logic                      ball_hit;

  // shared raster bus
  video_timing_if vt ();

  hvsync_generator u_hvsync (
    .clk   (clk),
    .reset (reset),
    .vt    (vt.source)
  );

  color_bars u_bars (
    .vt       (vt.sink),
    .grid_on  (grid_on),
    .bar_rgb  (bar_rgb),
    .grid_hit (grid_hit)
  );

  ball_sprite u_ball (
    .clk      (clk),
    .reset    (reset),
    .vt       (vt.sink),
    .ball_hit (ball_hit)
  );

  // one cycle of latency from raster to pins
  pixel_mixer u_mixer (
    .clk      (clk),
    .reset    (reset),
    .vt       (vt.sink),
    .bar_rgb  (bar_rgb),
    .grid_hit (grid_hit),
    .ball_hit (ball_hit),
    .hsync    (hsync),
    .vsync    (vsync),
    .de       (de),
    .rgb      (rgb)
  );

endmodule

// ==== logic/video_timing_if.sv ====
`timescale 1ns/1ns

// raster position and sync levels, one set per pixel clock
interface video_timing_if;

  logic [vga_pkg::POS_W-1:0] hpos; // current column
  logic [vga_pkg::POS_W-1:0] vpos; // current line
  logic                      hsync;
  logic                      vsync;
  logic                      display_on; // inside 640x480

  // generator side
  modport source (
    output hpos,
    output vpos,
    output hsync,
    output vsync,
    output display_on
  );

  // everything downstream only looks
  modport sink (
    input hpos,
    input vpos,
    input hsync,
    input vsync,
    input display_on
  );

endinterface

// ==== verif/tb_vga_top.sv ====
`timescale 1ns/1ns

// testbench for the vga subsystem with a raster and ball reference model
module tb_vga_top;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_FRAMES = 12;

  // raster sizes rebuilt from the individual widths
  localparam int H_TOTAL = int'(vga_pkg::H_DISPLAY) + int'(vga_pkg::H_FRONT) +
                           int'(vga_pkg::H_SYNC) + int'(vga_pkg::H_BACK);     // 800
  localparam int V_TOTAL = int'(vga_pkg::V_DISPLAY) + int'(vga_pkg::V_BOTTOM) +
                           int'(vga_pkg::V_SYNC) + int'(vga_pkg::V_TOP);      // 525
  localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
  localparam int WAIT_TIMEOUT  = FRAME_CYCLES + 2 * H_TOTAL; // a frame plus slack

  localparam int X_LIMIT    = int'(vga_pkg::H_DISPLAY) - int'(vga_pkg::BALL_SIZE); // 624
  localparam int Y_LIMIT    = int'(vga_pkg::V_DISPLAY) - int'(vga_pkg::BALL_SIZE); // 464
  localparam int STEP       = int'(vga_pkg::BALL_STEP);
  localparam int SIZE       = int'(vga_pkg::BALL_SIZE);
  localparam int GRID_PITCH = 1 << vga_pkg::GRID_SHIFT;

  logic                      clk;
  logic                      reset;
  logic                      grid_on;
  logic                      hsync;
  logic                      vsync;
  logic                      de;
  logic [vga_pkg::RGB_W-1:0] rgb;

  integer      seed;
  logic [31:0] rnd;
  int          frame;
  int          grid_frames  = 0; // frames drawn with the grid
  int          plain_frames = 0; // frames drawn without it

  // reference model of the raster and the ball
  int m_hpos;
  int m_vpos;
  int m_ball_x;
  int m_ball_y;
  bit m_dir_x;    // 1 = right
  bit m_dir_y;    // 1 = down
  int right_bounces  = 0;
  int bottom_bounces = 0;

  // same state one cycle later, lined up with the dut output register
  int   d_hpos;
  int   d_vpos;
  int   d_ball_x;
  int   d_ball_y;
  logic d_grid_on;
  bit   d_rst   = 1'b0; // outputs were cleared by reset
  bit   d_valid = 1'b0; // outputs carry a real pixel

  // expected outputs, all from the delayed copy
  logic                      exp_hsync;
  logic                      exp_vsync;
  logic                      exp_de;
  logic                      exp_grid;
  logic                      exp_ball;
  logic [vga_pkg::RGB_W-1:0] exp_bar;
  int                        bar_idx;

  vga_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .grid_on (grid_on),
    .hsync   (hsync),
    .vsync   (vsync),
    .de      (de),
    .rgb     (rgb)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // print the reason, then the fail line, then stop
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    stop_with_failure($sformatf("CHECK FAILED: %s expected 0x%0h got 0x%0h",
                                name, exp_val, act_val));
  endtask

  // one ball step along an axis
  function automatic int step_pos(input int pos, input bit dir);
    if (dir)
      return pos + STEP;
    else
      return pos - STEP;
  endfunction

  always @(posedge clk)
  begin : model_step
    int nx;
    int ny;
    bit ndx;
    bit ndy;
    // delayed copy first, from the values before this edge
    d_hpos    <= m_hpos;
    d_vpos    <= m_vpos;
    d_ball_x  <= m_ball_x;
    d_ball_y  <= m_ball_y;
    d_grid_on <= grid_on;
    d_rst     <= reset;
    d_valid   <= !reset;
    if (reset)
    begin
      m_hpos   <= 0;
      m_vpos   <= 0;
      m_ball_x <= int'(vga_pkg::BALL_X0);
      m_ball_y <= int'(vga_pkg::BALL_Y0);
      m_dir_x  <= 1'b1;
      m_dir_y  <= 1'b1;
    end
    else
    begin
      if (m_hpos == H_TOTAL - 1)
      begin
        m_hpos <= 0;                                          // new line
        m_vpos <= (m_vpos == V_TOTAL - 1) ? 0 : m_vpos + 1;
      end
      else
        m_hpos <= m_hpos + 1;
      // ball moves at the start of the first blanked line
      if (m_hpos == 0 && m_vpos == int'(vga_pkg::V_DISPLAY))
      begin
        ndx = m_dir_x;
        nx  = step_pos(m_ball_x, ndx);
        if (nx > X_LIMIT || nx < 0)
        begin
          ndx = ~ndx;                   // reflect then step back
          nx  = step_pos(m_ball_x, ndx);
          if (m_dir_x)
            right_bounces <= right_bounces + 1;
        end
        ndy = m_dir_y;
        ny  = step_pos(m_ball_y, ndy);
        if (ny > Y_LIMIT || ny < 0)
        begin
          ndy = ~ndy;
          ny  = step_pos(m_ball_y, ndy);
          if (m_dir_y)
            bottom_bounces <= bottom_bounces + 1;
        end
        m_ball_x <= nx;
        m_ball_y <= ny;
        m_dir_x  <= ndx;
        m_dir_y  <= ndy;
      end
    end
  end

  always_comb
  begin
    exp_hsync = (d_hpos >= int'(vga_pkg::H_SYNC_START)) &&
                (d_hpos <= int'(vga_pkg::H_SYNC_END));          // 656..751
    exp_vsync = (d_vpos >= int'(vga_pkg::V_SYNC_START)) &&
                (d_vpos <= int'(vga_pkg::V_SYNC_END));          // 490..491
    exp_de    = (d_hpos < int'(vga_pkg::H_DISPLAY)) &&
                (d_vpos < int'(vga_pkg::V_DISPLAY));
    exp_grid  = d_grid_on &&
                ((d_hpos % GRID_PITCH) == 0 || (d_vpos % GRID_PITCH) == 0);
    exp_ball  = (d_hpos >= d_ball_x) && (d_hpos < d_ball_x + SIZE) &&
                (d_vpos >= d_ball_y) && (d_vpos < d_ball_y + SIZE);
    bar_idx   = d_hpos / int'(vga_pkg::BAR_WIDTH);              // 80 wide bars
    exp_bar   = bar_idx[vga_pkg::RGB_W-1:0];
  end

  // outputs held clear by reset
  a_reset_hsync: assert property (@(posedge clk) d_rst |-> hsync == 1'b0)
    else report_mismatch("hsync", 32'(0), 32'($sampled(hsync)));
  a_reset_vsync: assert property (@(posedge clk) d_rst |-> vsync == 1'b0)
    else report_mismatch("vsync", 32'(0), 32'($sampled(vsync)));
  a_reset_de: assert property (@(posedge clk) d_rst |-> de == 1'b0)
    else report_mismatch("de", 32'(0), 32'($sampled(de)));
  a_reset_rgb: assert property (@(posedge clk) d_rst |-> rgb == vga_pkg::COLOR_BLANK)
    else report_mismatch("rgb", 32'(vga_pkg::COLOR_BLANK), 32'($sampled(rgb)));

  // raster timing
  a_hsync: assert property (@(posedge clk) d_valid |-> hsync == exp_hsync)
    else report_mismatch("hsync", 32'($sampled(exp_hsync)), 32'($sampled(hsync)));
  a_vsync: assert property (@(posedge clk) d_valid |-> vsync == exp_vsync)
    else report_mismatch("vsync", 32'($sampled(exp_vsync)), 32'($sampled(vsync)));
  a_de: assert property (@(posedge clk) d_valid |-> de == exp_de)
    else report_mismatch("de", 32'($sampled(exp_de)), 32'($sampled(de)));

  // picture outside the visible area is black
  a_blank: assert property (@(posedge clk) d_valid && !exp_de |-> rgb == vga_pkg::COLOR_BLANK)
    else report_mismatch("rgb", 32'(vga_pkg::COLOR_BLANK), 32'($sampled(rgb)));

  // plain bars also covers frames with the grid off
  a_bars: assert property (@(posedge clk)
      d_valid && exp_de && !exp_ball && !exp_grid |-> rgb == exp_bar)
    else report_mismatch("rgb", 32'($sampled(exp_bar)), 32'($sampled(rgb)));

  a_grid: assert property (@(posedge clk)
      d_valid && exp_de && !exp_ball && exp_grid |-> rgb == vga_pkg::COLOR_GRID)
    else report_mismatch("rgb", 32'(vga_pkg::COLOR_GRID), 32'($sampled(rgb)));

  // ball wins over grid and bars
  a_ball: assert property (@(posedge clk)
      d_valid && exp_de && exp_ball |-> rgb == vga_pkg::COLOR_BALL)
    else report_mismatch("rgb", 32'(vga_pkg::COLOR_BALL), 32'($sampled(rgb)));

  // next vsync pulse at the pins, skipping one already in progress
  task automatic wait_for_vsync();
    int  count;
    bit  seen_low;
    count    = 0;
    seen_low = 1'b0;
    while (!(seen_low && vsync === 1'b1))
    begin
      if (vsync === 1'b0)
        seen_low = 1'b1;
      @(posedge clk);
      count++;
      if (count > WAIT_TIMEOUT)
        stop_with_failure("timeout while waiting for a vsync pulse from the DUT");
    end
  endtask

  // first visible pixel after the current blanking
  task automatic wait_for_de();
    int count;
    bit seen_low;
    count    = 0;
    seen_low = 1'b0;
    while (!(seen_low && de === 1'b1))
    begin
      if (de === 1'b0)
        seen_low = 1'b1;
      @(posedge clk);
      count++;
      if (count > WAIT_TIMEOUT)
        stop_with_failure("timeout while waiting for the DUT to start a visible line");
    end
  endtask

  // fresh grid setting for the frame that starts now
  task automatic pick_grid_setting();
    rnd = $random(seed);
    grid_on <= rnd[0];
    if (rnd[0])
      grid_frames++;
    else
      plain_frames++;
  endtask

  task automatic finish_run();
    $display("ball bounces seen: right %0d bottom %0d", right_bounces, bottom_bounces);
    $display("frames with grid %0d without grid %0d", grid_frames, plain_frames);
    if (right_bounces > 0 && bottom_bounces > 0 && grid_frames > 0 && plain_frames > 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
      stop_with_failure("the ball did not bounce off both edges or the grid was never toggled");
  endtask

  initial
  begin
    seed    = 32'h060f_7d0b;
    reset   = 1'b1;
    grid_on = 1'b0;
    repeat (4) @(posedge clk);   // four reset cycles
    reset <= 1'b0;
    pick_grid_setting();         // frame 0 starts with the release
    for (frame = 1; frame < NUM_FRAMES; frame++)
    begin
      wait_for_vsync();
      wait_for_de();             // top left pixel of the next frame
      pick_grid_setting();
    end
    wait_for_vsync();            // last frame has had its ball update
    finish_run();
  end

endmodule
